//--- Bender.yml
package:
  name: multicycle_control

sources:
  - mipsCtrlPkg.sv
  - instrDecoder.sv
  - controlSequencer.sv
  - controlOutputs.sv
  - multicycleControl.sv
  - target: test
    files:
      - multicycleControl_asserts.sv
      - multicycleControl_tb.sv

//--- controlOutputs.sv
`default_nettype none
`timescale 1ns/1ps

module controlOutputs
(
	input  mipsCtrlPkg::ctrlStateT state,
	input  logic                   AluZero,
	output logic                   PcLoad,
	output logic                   Wr,	// memory write, read otherwise
	output logic                   IrWrite,
	output logic                   RegWrite,
	output logic                   RegsReset,
	output logic                   RegDst,
	output logic                   IorD,	// 1 selects data address
	output logic                   ALoad,
	output logic                   BLoad,
	output logic                   MdrLoad,
	output logic                   AluOutLoad,
	output mipsCtrlPkg::aluSelT    AluSel,
	output logic                   AluSrcA,
	output logic [1:0]             AluSrcB,
	output logic [1:0]             PcSource,
	output logic [1:0]             MemtoReg
);
	import mipsCtrlPkg::*;

	always_comb
	begin
		PcLoad     = 1'b0;
		Wr         = 1'b0;
		IrWrite    = 1'b0;
		RegWrite   = 1'b0;
		RegsReset  = 1'b0;
		RegDst     = 1'b0;
		IorD       = 1'b0;
		ALoad      = 1'b0;
		BLoad      = 1'b0;
		MdrLoad    = 1'b0;
		AluOutLoad = 1'b0;
		AluSel     = AluNone;
		AluSrcA    = SrcAPc;
		AluSrcB    = SrcBReg;
		PcSource   = PcSrcAlu;
		MemtoReg   = MemtoRegAluOut;

		case (state)
			Reset:
				RegsReset = 1'b1;	// clears A, B, PC, MDR, ALUOut, IR and regfile
			Fetch,
			FetchDelay1:
			begin
				IrWrite = 1'b1;	// hold the read until data settles
				MdrLoad = 1'b1;
				AluSrcB = SrcBFour;
			end
			FetchDelay2:
			begin
				IrWrite = 1'b1;
				MdrLoad = 1'b1;
				PcLoad  = 1'b1;	// PC <= PC + 4
				AluSel  = AluAdd;
				AluSrcB = SrcBFour;
			end
			Decode:
			begin
				ALoad      = 1'b1;
				BLoad      = 1'b1;
				AluOutLoad = 1'b1;	// branch target kept in ALUOut
				AluSel     = AluAdd;
				AluSrcB    = SrcBImmShift;
			end
			Add,
			And,
			Sub,
			Xor:
			begin
				AluOutLoad = 1'b1;
				AluSrcA    = SrcAReg;
				AluSrcB    = SrcBReg;
				case (state)
					And:     AluSel = AluAnd;
					Sub:     AluSel = AluSub;
					Xor:     AluSel = AluXor;
					default: AluSel = AluAdd;
				endcase
			end
			RWait:
			begin
				RegWrite = 1'b1;
				RegDst   = 1'b1;	// rd field
				MemtoReg = MemtoRegAluOut;
			end
			Beq,
			Bne:
			begin
				PcLoad   = (state == Beq) ? AluZero : ~AluZero;
				AluSel   = AluSub;	// compare A and B
				AluSrcA  = SrcAReg;
				PcSource = PcSrcAluOut;
			end
			J:
			begin
				PcLoad     = 1'b1;
				PcSource   = PcSrcJump;
				AluSel     = AluAdd;
				AluSrcB    = SrcBImmShift;
				IorD       = 1'b1;
				AluOutLoad = 1'b1;
			end
			Lui:
			begin
				RegWrite = 1'b1;	// rt gets the immediate
				MemtoReg = MemtoRegImm;
			end
			LwAddrComp,
			SwAddrComp:
			begin
				AluSel     = AluAdd;	// A + offset
				AluSrcA    = SrcAReg;
				AluSrcB    = SrcBImm;
				AluOutLoad = 1'b1;
			end
			Lw,
			LwDelay1,
			LwDelay2:
			begin
				IorD    = 1'b1;
				MdrLoad = 1'b1;
			end
			Sw,
			SwDelay:
			begin
				Wr   = 1'b1;
				IorD = 1'b1;
			end
			WriteBack:
			begin
				RegWrite = 1'b1;
				MemtoReg = MemtoRegMdr;	// loaded word into rt
			end
			default:
				AluSel = AluNone;	// Nop, Break and illegal states stay idle
		endcase
	end

endmodule

`default_nettype wire

//--- controlSequencer.sv
`default_nettype none
`timescale 1ns/1ps

module controlSequencer
(
	input  logic                   Clk,
	input  logic                   Reset_signal,
	input  mipsCtrlPkg::ctrlStateT dispatchState,	// valid during Decode
	output mipsCtrlPkg::ctrlStateT state
);
	import mipsCtrlPkg::*;

	ctrlStateT nextState;

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
			state <= Reset;
		else
			state <= nextState;
	end

	always_comb
	begin
		case (state)
			Reset:       nextState = Fetch;
			Fetch:       nextState = FetchDelay1;	// memory read wait
			FetchDelay1: nextState = FetchDelay2;
			FetchDelay2: nextState = Decode;
			Decode:      nextState = dispatchState;

			Add,
			And,
			Sub,
			Xor:         nextState = RWait;	// result written next cycle
			Break:       nextState = Break;	// halt until reset

			LwAddrComp:  nextState = Lw;
			Lw:          nextState = LwDelay1;
			LwDelay1:    nextState = LwDelay2;
			LwDelay2:    nextState = WriteBack;

			SwAddrComp:  nextState = Sw;
			Sw:          nextState = SwDelay;	// write held for two cycles

			RWait,
			Nop,
			Beq,
			Bne,
			J,
			Lui,
			WriteBack,
			SwDelay:     nextState = Fetch;

			default:     nextState = Reset;	// illegal encoding
		endcase
	end

endmodule

`default_nettype wire

//--- filelist.f
mipsCtrlPkg.sv
instrDecoder.sv
controlSequencer.sv
controlOutputs.sv
multicycleControl.sv
multicycleControl_asserts.sv
multicycleControl_tb.sv

//--- instrDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module instrDecoder
(
	input  logic [mipsCtrlPkg::OpWidth-1:0] Op,
	input  logic [mipsCtrlPkg::OpWidth-1:0] Funct,	// only meaningful for R-type
	output mipsCtrlPkg::ctrlStateT          dispatchState
);
	import mipsCtrlPkg::*;

	opcodeT opCode;
	functT  functCode;

	assign opCode    = opcodeT'(Op);
	assign functCode = functT'(Funct);

	always_comb
	begin
		case (opCode)
			FunctOp:
			begin
				case (functCode)
					AddFunct:   dispatchState = Add;
					AndFunct:   dispatchState = And;
					SubFunct:   dispatchState = Sub;
					XorFunct:   dispatchState = Xor;
					BreakFunct: dispatchState = Break;
					NopFunct:   dispatchState = Nop;
					default:    dispatchState = Nop;	// unknown funct runs as nop
				endcase
			end
			BeqOp:   dispatchState = Beq;
			BneOp:   dispatchState = Bne;
			JOp:     dispatchState = J;
			LuiOp:   dispatchState = Lui;
			LwOp:    dispatchState = LwAddrComp;	// address first
			SwOp:    dispatchState = SwAddrComp;
			default: dispatchState = Nop;	// unknown opcode
		endcase
	end

endmodule

`default_nettype wire

//--- mipsCtrlPkg.sv
`default_nettype none

package mipsCtrlPkg;

	localparam int OpWidth = 6;	// opcode and funct field width

	typedef enum logic [OpWidth-1:0]
	{
		FunctOp = 6'h00,	// R-type, operation in funct
		JOp     = 6'h02,
		BeqOp   = 6'h04,
		BneOp   = 6'h05,
		LuiOp   = 6'h0F,
		LwOp    = 6'h23,
		SwOp    = 6'h2B
	} opcodeT;

	typedef enum logic [OpWidth-1:0]
	{
		NopFunct   = 6'h00,
		BreakFunct = 6'h0D,
		AddFunct   = 6'h20,
		SubFunct   = 6'h22,
		AndFunct   = 6'h24,
		XorFunct   = 6'h26
	} functT;

	// numbering follows the StateOut encoding seen by the datapath
	typedef enum logic [7:0]
	{
		Reset,
		Fetch, FetchDelay1, FetchDelay2,
		Decode,
		Beq, Bne, Lw, Sw, Lui, J, Nop,
		Add, RWait, And, Sub, Xor, Break,
		LwAddrComp, SwAddrComp, WriteBack, LwDelay1, LwDelay2, SwDelay
	} ctrlStateT;

	typedef enum logic [2:0]
	{
		AluNone = 3'b000,
		AluAdd  = 3'b001,
		AluSub  = 3'b010,
		AluAnd  = 3'b011,
		AluXor  = 3'b110
	} aluSelT;

	localparam logic SrcAPc  = 1'b0;	// alu operand A from PC
	localparam logic SrcAReg = 1'b1;	// alu operand A from register A

	localparam logic [1:0] SrcBReg      = 2'b00;	// register B
	localparam logic [1:0] SrcBFour     = 2'b01;	// constant 4 for PC increment
	localparam logic [1:0] SrcBImm      = 2'b10;	// sign extended offset
	localparam logic [1:0] SrcBImmShift = 2'b11;	// offset shifted left by 2

	localparam logic [1:0] PcSrcAlu    = 2'b00;	// alu result, PC + 4
	localparam logic [1:0] PcSrcAluOut = 2'b01;	// branch target from ALUOut
	localparam logic [1:0] PcSrcJump   = 2'b10;	// jump target from IR

	localparam logic [1:0] MemtoRegAluOut = 2'b00;
	localparam logic [1:0] MemtoRegMdr    = 2'b01;
	localparam logic [1:0] MemtoRegImm    = 2'b10;	// upper immediate for LUI

endpackage

`default_nettype wire

//--- multicycleControl.sv
`default_nettype none
`timescale 1ns/1ps

module multicycleControl
(
	input  logic                            Clk,
	input  logic                            Reset_signal,
	input  logic [mipsCtrlPkg::OpWidth-1:0] Op,
	input  logic [mipsCtrlPkg::OpWidth-1:0] Funct,
	input  logic                            AluZero,
	output mipsCtrlPkg::ctrlStateT          StateOut,
	output logic                            PcLoad,
	output logic                            Wr,
	output logic                            IrWrite,
	output logic                            RegWrite,
	output logic                            RegsReset,
	output logic                            RegDst,
	output logic                            IorD,
	output logic                            ALoad,
	output logic                            BLoad,
	output logic                            MdrLoad,
	output logic                            AluOutLoad,
	output mipsCtrlPkg::aluSelT             AluSel,
	output logic                            AluSrcA,
	output logic [1:0]                      AluSrcB,
	output logic [1:0]                      PcSource,
	output logic [1:0]                      MemtoReg
);
	import mipsCtrlPkg::*;

	ctrlStateT dispatchState;	// decoder result for the Decode step

	instrDecoder decoder
	(
		.Op            (Op),
		.Funct         (Funct),
		.dispatchState (dispatchState)
	);

	controlSequencer sequencer
	(
		.Clk           (Clk),
		.Reset_signal  (Reset_signal),
		.dispatchState (dispatchState),
		.state         (StateOut)	// registered state is the exported one
	);

	controlOutputs outputs
	(
		.state      (StateOut),
		.AluZero    (AluZero),
		.PcLoad     (PcLoad),
		.Wr         (Wr),
		.IrWrite    (IrWrite),
		.RegWrite   (RegWrite),
		.RegsReset  (RegsReset),
		.RegDst     (RegDst),
		.IorD       (IorD),
		.ALoad      (ALoad),
		.BLoad      (BLoad),
		.MdrLoad    (MdrLoad),
		.AluOutLoad (AluOutLoad),
		.AluSel     (AluSel),
		.AluSrcA    (AluSrcA),
		.AluSrcB    (AluSrcB),
		.PcSource   (PcSource),
		.MemtoReg   (MemtoReg)
	);

endmodule

`default_nettype wire

//--- multicycleControl_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module multicycleControl_asserts
(
	input logic                   Clk,
	input logic                   Reset_signal,
	input mipsCtrlPkg::ctrlStateT StateOut,
	input logic                   Wr,
	input logic                   PcLoad,
	input logic                   RegsReset,
	input logic                   RegWrite
);
	import mipsCtrlPkg::*;

	wrOnlyInStore: assert property (@(posedge Clk)
		Wr |-> (StateOut == Sw || StateOut == SwDelay))
		else $error("memory write outside the store states");

	noPcLoadInReset: assert property (@(posedge Clk)
		!(PcLoad && RegsReset))
		else $error("PC load while registers are held in reset");

	// release of reset always starts a fetch
	resetThenFetch: assert property (@(posedge Clk) disable iff (Reset_signal)
		StateOut == Reset |=> StateOut == Fetch)
		else $error("reset state not followed by fetch");

	noWrWithRegWrite: assert property (@(posedge Clk)
		!(Wr && RegWrite))
		else $error("memory write and register write together");

endmodule

bind multicycleControl multicycleControl_asserts checks (.*);

`default_nettype wire

//--- multicycleControl_tb.sv
`default_nettype none
`timescale 1ns/1ps

module multicycleControl_tb;
	import mipsCtrlPkg::*;

	localparam int ClkPeriod = 20;
	localparam int NumRows = 20;	// second half draws AluZero at random

	logic Clk;
	logic Reset_signal;
	logic [OpWidth-1:0] Op;
	logic [OpWidth-1:0] Funct;
	logic AluZero;
	ctrlStateT StateOut;
	logic PcLoad, Wr, IrWrite, RegWrite, RegsReset, RegDst, IorD;
	logic ALoad, BLoad, MdrLoad, AluOutLoad, AluSrcA;
	aluSelT AluSel;
	logic [1:0] AluSrcB, PcSource, MemtoReg;

	integer seed;
	integer randVal;
	ctrlStateT expQ [$];	// expected state walk of one instruction

	// ADD AND SUB XOR NOP undef BEQ BEQ BNE BNE | J LUI LW SW undef BEQ BNE LW J BREAK
	logic [5:0] opTab [0:NumRows-1] = '{6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h04,
		6'h04, 6'h05, 6'h05, 6'h02, 6'h0F, 6'h23, 6'h2B, 6'h3F, 6'h04, 6'h05, 6'h23, 6'h02, 6'h00};
	logic [5:0] fnTab [0:NumRows-1] = '{6'h20, 6'h24, 6'h22, 6'h26, 6'h00, 6'h3F, 6'h00,
		6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h0D};
	logic zeroTab [0:NumRows-1] = '{0, 1, 0, 1, 1, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};

	multicycleControl uut
	(
		.Clk(Clk), .Reset_signal(Reset_signal), .Op(Op), .Funct(Funct), .AluZero(AluZero),
		.StateOut(StateOut), .PcLoad(PcLoad), .Wr(Wr), .IrWrite(IrWrite), .RegWrite(RegWrite),
		.RegsReset(RegsReset), .RegDst(RegDst), .IorD(IorD), .ALoad(ALoad), .BLoad(BLoad),
		.MdrLoad(MdrLoad), .AluOutLoad(AluOutLoad), .AluSel(AluSel), .AluSrcA(AluSrcA),
		.AluSrcB(AluSrcB), .PcSource(PcSource), .MemtoReg(MemtoReg)
	);

	initial
	begin
		Clk = 1'b0;
		forever #(ClkPeriod / 2) Clk = ~Clk;
	end

	task automatic failRun();
		$display("Testbench failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkState(input ctrlStateT got, input ctrlStateT exp, input string what);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
			failRun();
		end
	endtask

	task automatic checkAluSel(input aluSelT got, input aluSelT exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: AluSel is %s, expected %s", $time, got.name(), exp.name());
			failRun();
		end
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			failRun();
		end
	endtask

	task automatic checkSel(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			failRun();
		end
	endtask

	// walk after the four fetch and decode cycles, from the timing table
	task automatic buildWalk(input logic [5:0] op, input logic [5:0] fn);
		expQ = {};
		expQ.push_back(Fetch);
		expQ.push_back(FetchDelay1);
		expQ.push_back(FetchDelay2);
		expQ.push_back(Decode);
		case (op)
			LwOp:
			begin
				expQ.push_back(LwAddrComp);
				expQ.push_back(Lw);
				expQ.push_back(LwDelay1);
				expQ.push_back(LwDelay2);
				expQ.push_back(WriteBack);
			end
			SwOp:
			begin
				expQ.push_back(SwAddrComp);
				expQ.push_back(Sw);
				expQ.push_back(SwDelay);
			end
			BeqOp: expQ.push_back(Beq);
			BneOp: expQ.push_back(Bne);
			JOp:   expQ.push_back(J);
			LuiOp: expQ.push_back(Lui);
			FunctOp:
			begin
				case (fn)
					AddFunct: expQ.push_back(Add);
					AndFunct: expQ.push_back(And);
					SubFunct: expQ.push_back(Sub);
					XorFunct: expQ.push_back(Xor);
					BreakFunct: repeat (20) expQ.push_back(Break);	// halted
					default:  expQ.push_back(Nop);
				endcase
				if (fn == AddFunct || fn == AndFunct || fn == SubFunct || fn == XorFunct)
					expQ.push_back(RWait);
			end
			default: expQ.push_back(Nop);	// undefined opcode
		endcase
	endtask

	task automatic checkCycle(input ctrlStateT exp, input logic zero);
		logic fetchSt;
		logic memSt;
		logic rOp;
		logic addrSt;
		fetchSt = (exp == Fetch || exp == FetchDelay1 || exp == FetchDelay2);
		memSt = (exp == Lw || exp == LwDelay1 || exp == LwDelay2);
		rOp = (exp == Add || exp == And || exp == Sub || exp == Xor);
		addrSt = (exp == LwAddrComp || exp == SwAddrComp);
		checkState(StateOut, exp, "StateOut");
		checkBit(PcLoad, exp == FetchDelay2 || exp == J || (exp == Beq && zero)
			|| (exp == Bne && !zero), "PcLoad");
		checkBit(Wr, exp == Sw || exp == SwDelay, "Wr");
		checkBit(IrWrite, fetchSt, "IrWrite");
		checkBit(MdrLoad, fetchSt || memSt, "MdrLoad");
		checkBit(RegWrite, exp == RWait || exp == Lui || exp == WriteBack, "RegWrite");
		checkBit(RegsReset, exp == Reset, "RegsReset");
		checkBit(ALoad, exp == Decode, "ALoad");
		checkBit(BLoad, exp == Decode, "BLoad");
		checkBit(RegDst, exp == RWait, "RegDst");
		if (exp == Reset || fetchSt || memSt || exp == Sw || exp == SwDelay)
			checkBit(IorD, memSt || exp == Sw || exp == SwDelay, "IorD");
		if (exp == Reset || exp == Decode || rOp)
			checkBit(AluOutLoad, exp != Reset, "AluOutLoad");
		checkBit(AluSrcA, (rOp || exp == Beq || exp == Bne || addrSt) ? SrcAReg : SrcAPc,
			"AluSrcA");
		if (fetchSt)
			checkSel(AluSrcB, SrcBFour, "AluSrcB");	// PC + 4
		else if (exp == Decode)
			checkSel(AluSrcB, SrcBImmShift, "AluSrcB");
		else if (addrSt)
			checkSel(AluSrcB, SrcBImm, "AluSrcB");
		else if (rOp || exp == Beq || exp == Bne)
			checkSel(AluSrcB, SrcBReg, "AluSrcB");
		case (exp)
			FetchDelay2, Decode, Add, LwAddrComp, SwAddrComp: checkAluSel(AluSel, AluAdd);
			And: checkAluSel(AluSel, AluAnd);
			Sub: checkAluSel(AluSel, AluSub);
			Xor: checkAluSel(AluSel, AluXor);
			Beq, Bne:
			begin
				checkSel(PcSource, PcSrcAluOut, "PcSource");
				checkAluSel(AluSel, AluSub);	// zero flag from A - B
			end
			J: checkSel(PcSource, PcSrcJump, "PcSource");
			Lui: checkSel(MemtoReg, MemtoRegImm, "MemtoReg");
			WriteBack: checkSel(MemtoReg, MemtoRegMdr, "MemtoReg");
			default: ;
		endcase
	endtask

	initial
	begin
		#((NumRows * 9 + 10 + 20 + 40) * ClkPeriod);	// rows, reset, break hold, margin
		$display("Timeout: the state walk did not finish in the expected time");
		failRun();
	end

	initial
	begin
		seed = 46;
		Reset_signal = 1'b1;
		Op = '0;
		Funct = '0;
		AluZero = 1'b0;
		repeat (10)
		begin
			@(negedge Clk);
			checkCycle(Reset, 1'b0);
		end
		Reset_signal = 1'b0;
		@(negedge Clk);	// Fetch from here on
		for (int i = 0; i < NumRows; i++)
		begin
			Op = opTab[i];
			Funct = fnTab[i];
			if (i < NumRows / 2)
				AluZero = zeroTab[i];
			else
			begin
				randVal = $random(seed);
				AluZero = randVal[0];
			end
			buildWalk(opTab[i], fnTab[i]);
			foreach (expQ[k])
			begin
				checkCycle(expQ[k], AluZero);
				@(negedge Clk);
			end
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
